/* design/cache_pkg.sv */
package cache_pkg;

    // data and address widths
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // address fields: tag | set index | word offset
    typedef logic [11:0] tag_t;
    typedef logic [1:0]  index_t;
    typedef logic [1:0]  offset_t;

    // cache geometry
    localparam int BLOCK_WORDS = 4;
    localparam int NUM_SETS    = 4;

    // main memory size in words
    localparam int MEM_DEPTH = 65536;

    // word a of memory holds a ^ MEM_PATTERN after reset
    localparam word_t MEM_PATTERN = 16'hA5C3;

    // shared by both caches
    typedef enum logic [2:0] {
        idle,
        wait_grant,
        refill,
        write_mem,
        respond
    } cache_state_t;

endpackage

/* design/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             i_req,
    input  cache_pkg::addr_t i_addr,
    output logic             i_done,
    output cache_pkg::word_t i_data,
    output logic             i_hit,
    input  logic             d_req,
    input  logic             d_we,
    input  cache_pkg::addr_t d_addr,
    input  cache_pkg::word_t d_wdata,
    output logic             d_done,
    output cache_pkg::word_t d_rdata,
    output logic             d_hit
);

    // cache side of the arbiter
    logic             ic_mem_req;
    cache_pkg::addr_t ic_mem_addr;
    logic             ic_grant;
    logic             ic_valid;
    logic             ic_last;
    logic             dc_mem_req;
    logic             dc_mem_we;
    cache_pkg::addr_t dc_mem_addr;
    cache_pkg::word_t dc_mem_wdata;
    logic             dc_grant;
    logic             dc_valid;
    logic             dc_last;

    // memory side
    logic             mem_start;
    logic             mem_we;
    cache_pkg::addr_t mem_addr;
    cache_pkg::word_t mem_wdata;
    logic             mem_valid;
    logic             mem_last;
    cache_pkg::word_t mem_rdata;

    icache u_icache (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_req     (i_req),
        .i_addr    (i_addr),
        .i_done    (i_done),
        .i_data    (i_data),
        .i_hit     (i_hit),
        .mem_req   (ic_mem_req),
        .mem_addr  (ic_mem_addr),
        .mem_grant (ic_grant),
        .mem_valid (ic_valid),
        .mem_last  (ic_last),
        .mem_rdata (mem_rdata)
    );

    dcache u_dcache (
        .clk       (clk),
        .reset_n   (reset_n),
        .d_req     (d_req),
        .d_we      (d_we),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_done    (d_done),
        .d_rdata   (d_rdata),
        .d_hit     (d_hit),
        .mem_req   (dc_mem_req),
        .mem_we    (dc_mem_we),
        .mem_addr  (dc_mem_addr),
        .mem_wdata (dc_mem_wdata),
        .mem_grant (dc_grant),
        .mem_valid (dc_valid),
        .mem_last  (dc_last),
        .mem_rdata (mem_rdata)
    );

    mem_arbiter u_arbiter (
        .clk          (clk),
        .reset_n      (reset_n),
        .ic_mem_req   (ic_mem_req),
        .ic_mem_addr  (ic_mem_addr),
        .dc_mem_req   (dc_mem_req),
        .dc_mem_we    (dc_mem_we),
        .dc_mem_addr  (dc_mem_addr),
        .dc_mem_wdata (dc_mem_wdata),
        .mem_valid    (mem_valid),
        .mem_last     (mem_last),
        .ic_grant     (ic_grant),
        .dc_grant     (dc_grant),
        .ic_valid     (ic_valid),
        .ic_last      (ic_last),
        .dc_valid     (dc_valid),
        .dc_last      (dc_last),
        .mem_start    (mem_start),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    main_memory u_memory (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_start (mem_start),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_valid (mem_valid),
        .mem_last  (mem_last),
        .mem_rdata (mem_rdata)
    );

endmodule

/* design/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             d_req,
    input  logic             d_we,
    input  cache_pkg::addr_t d_addr,
    input  cache_pkg::word_t d_wdata,
    output logic             d_done,
    output cache_pkg::word_t d_rdata,
    output logic             d_hit,
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    input  logic             mem_grant,
    input  logic             mem_valid,
    input  logic             mem_last,
    input  cache_pkg::word_t mem_rdata
);

    cache_pkg::cache_state_t state;
    cache_pkg::addr_t        req_addr;
    logic                    req_we;
    cache_pkg::offset_t      fill_cnt;

    logic [cache_pkg::NUM_SETS-1:0] valid;
    cache_pkg::tag_t  tags [cache_pkg::NUM_SETS];
    cache_pkg::word_t data_mem [cache_pkg::NUM_SETS][cache_pkg::BLOCK_WORDS];

    cache_pkg::tag_t    in_tag;
    cache_pkg::index_t  in_idx;
    cache_pkg::offset_t in_off;
    cache_pkg::index_t  req_idx;
    cache_pkg::offset_t req_off;
    logic               accept;
    logic               lookup_hit;

    assign in_tag  = d_addr[15:4];
    assign in_idx  = d_addr[3:2];
    assign in_off  = d_addr[1:0];
    assign req_idx = req_addr[3:2];
    assign req_off = req_addr[1:0];

    assign accept = d_req && (state == cache_pkg::idle || state == cache_pkg::respond);

    assign lookup_hit = valid[in_idx] && (tags[in_idx] == in_tag);

    assign d_done  = (state == cache_pkg::respond);
    assign mem_req = (state == cache_pkg::wait_grant) || (state == cache_pkg::refill) ||
                     (state == cache_pkg::write_mem);
    assign mem_we  = mem_req && req_we;

    // writes go to the exact word, reads fetch the aligned block
    assign mem_addr = req_we ? req_addr : {req_addr[15:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= cache_pkg::idle;
            valid    <= '0;
            d_hit    <= 1'b0;
            fill_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::idle, cache_pkg::respond: begin
                    state <= cache_pkg::idle;
                    if (d_req) begin
                        d_hit <= lookup_hit;
                        // every write goes through to memory
                        if (d_we || !lookup_hit) begin
                            state <= cache_pkg::wait_grant;
                        end else begin
                            state <= cache_pkg::respond;
                        end
                    end
                end
                cache_pkg::wait_grant: begin
                    if (mem_grant) begin
                        state    <= req_we ? cache_pkg::write_mem : cache_pkg::refill;
                        fill_cnt <= '0;
                    end
                end
                cache_pkg::refill: begin
                    if (mem_valid) begin
                        fill_cnt <= fill_cnt + 2'd1;
                        if (mem_last) begin
                            valid[req_idx] <= 1'b1;
                            state          <= cache_pkg::respond;
                        end
                    end
                end
                cache_pkg::write_mem: begin
                    // memory acks the single-word write with mem_last
                    if (mem_last) begin
                        state <= cache_pkg::respond;
                    end
                end
                default: state <= cache_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= d_addr;
            req_we    <= d_we;
            mem_wdata <= d_wdata;
            d_rdata   <= data_mem[in_idx][in_off];
            // write hit updates the cached copy, a miss leaves the set alone
            if (d_we && lookup_hit) begin
                data_mem[in_idx][in_off] <= d_wdata;
            end
        end
        if (state == cache_pkg::refill && mem_valid) begin
            data_mem[req_idx][fill_cnt] <= mem_rdata;
            if (fill_cnt == req_off) begin
                d_rdata <= mem_rdata;
            end
            if (mem_last) begin
                tags[req_idx] <= req_addr[15:4];
            end
        end
    end

endmodule

/* design/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             i_req,
    input  cache_pkg::addr_t i_addr,
    output logic             i_done,
    output cache_pkg::word_t i_data,
    output logic             i_hit,
    output logic             mem_req,
    output cache_pkg::addr_t mem_addr,
    input  logic             mem_grant,
    input  logic             mem_valid,
    input  logic             mem_last,
    input  cache_pkg::word_t mem_rdata
);

    cache_pkg::cache_state_t state;
    cache_pkg::addr_t        req_addr;
    cache_pkg::offset_t      fill_cnt;

    logic [cache_pkg::NUM_SETS-1:0] valid;
    cache_pkg::tag_t  tags [cache_pkg::NUM_SETS];
    cache_pkg::word_t data_mem [cache_pkg::NUM_SETS][cache_pkg::BLOCK_WORDS];

    cache_pkg::tag_t    in_tag;
    cache_pkg::index_t  in_idx;
    cache_pkg::offset_t in_off;
    cache_pkg::index_t  req_idx;
    cache_pkg::offset_t req_off;
    logic               accept;
    logic               lookup_hit;

    // fields of the incoming and the latched address
    assign in_tag  = i_addr[15:4];
    assign in_idx  = i_addr[3:2];
    assign in_off  = i_addr[1:0];
    assign req_idx = req_addr[3:2];
    assign req_off = req_addr[1:0];

    // a new request can follow directly on the done cycle
    assign accept = i_req && (state == cache_pkg::idle || state == cache_pkg::respond);

    assign lookup_hit = valid[in_idx] && (tags[in_idx] == in_tag);

    assign i_done   = (state == cache_pkg::respond);
    assign mem_req  = (state == cache_pkg::wait_grant) || (state == cache_pkg::refill);
    assign mem_addr = {req_addr[15:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= cache_pkg::idle;
            valid    <= '0;
            i_hit    <= 1'b0;
            fill_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::idle, cache_pkg::respond: begin
                    state <= cache_pkg::idle;
                    if (i_req) begin
                        i_hit <= lookup_hit;
                        state <= lookup_hit ? cache_pkg::respond : cache_pkg::wait_grant;
                    end
                end
                cache_pkg::wait_grant: begin
                    if (mem_grant) begin
                        state    <= cache_pkg::refill;
                        fill_cnt <= '0;
                    end
                end
                cache_pkg::refill: begin
                    if (mem_valid) begin
                        fill_cnt <= fill_cnt + 2'd1;
                        // block complete on the last beat
                        if (mem_last) begin
                            valid[req_idx] <= 1'b1;
                            state          <= cache_pkg::respond;
                        end
                    end
                end
                default: state <= cache_pkg::idle;
            endcase
        end
    end

    // tag and data arrays, read data
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= i_addr;
            i_data   <= data_mem[in_idx][in_off];
        end
        if (state == cache_pkg::refill && mem_valid) begin
            data_mem[req_idx][fill_cnt] <= mem_rdata;
            // forward the requested word as it streams in
            if (fill_cnt == req_off) begin
                i_data <= mem_rdata;
            end
            if (mem_last) begin
                tags[req_idx] <= req_addr[15:4];
            end
        end
    end

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             mem_start,
    input  logic             mem_we,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    output logic             mem_valid,
    output logic             mem_last,
    output cache_pkg::word_t mem_rdata
);

    cache_pkg::word_t   mem [cache_pkg::MEM_DEPTH];
    logic               burst_active;
    logic [13:0]        burst_base;
    cache_pkg::offset_t burst_cnt;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            burst_active <= 1'b0;
            burst_cnt    <= '0;
            mem_valid    <= 1'b0;
            mem_last     <= 1'b0;
        end else begin
            mem_valid <= 1'b0;
            mem_last  <= 1'b0;
            if (mem_start && mem_we) begin
                // single-word write, acked right away
                mem_last <= 1'b1;
            end else if (mem_start) begin
                // offset 0 goes out now, the rest follow
                burst_active <= 1'b1;
                burst_base   <= mem_addr[15:2];
                burst_cnt    <= 2'd1;
                mem_valid    <= 1'b1;
            end else if (burst_active) begin
                burst_cnt <= burst_cnt + 2'd1;
                mem_valid <= 1'b1;
                if (burst_cnt == 2'd3) begin
                    mem_last     <= 1'b1;
                    burst_active <= 1'b0;
                end
            end
        end
    end

    // array and read data, pattern loaded while in reset
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int a = 0; a < cache_pkg::MEM_DEPTH; a++) begin
                mem[a] <= cache_pkg::word_t'(a) ^ cache_pkg::MEM_PATTERN;
            end
        end else if (mem_start && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end else if (mem_start) begin
            mem_rdata <= mem[{mem_addr[15:2], 2'b00}];
        end else if (burst_active) begin
            mem_rdata <= mem[{burst_base, burst_cnt}];
        end
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             ic_mem_req,
    input  cache_pkg::addr_t ic_mem_addr,
    input  logic             dc_mem_req,
    input  logic             dc_mem_we,
    input  cache_pkg::addr_t dc_mem_addr,
    input  cache_pkg::word_t dc_mem_wdata,
    input  logic             mem_valid,
    input  logic             mem_last,
    output logic             ic_grant,
    output logic             dc_grant,
    output logic             ic_valid,
    output logic             ic_last,
    output logic             dc_valid,
    output logic             dc_last,
    output logic             mem_start,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata
);

    typedef enum logic [1:0] {
        own_none,
        own_ic,
        own_dc
    } owner_t;

    owner_t owner;
    logic   sel_dc;

    // grant only from idle, data side wins a tie
    assign dc_grant  = (owner == own_none) && dc_mem_req;
    assign ic_grant  = (owner == own_none) && ic_mem_req && !dc_mem_req;
    assign mem_start = ic_grant || dc_grant;

    // memory samples the command in the grant cycle
    assign sel_dc    = dc_grant || (owner == own_dc);
    assign mem_we    = sel_dc && dc_mem_we;
    assign mem_addr  = sel_dc ? dc_mem_addr : ic_mem_addr;
    assign mem_wdata = dc_mem_wdata;

    // returns only reach the current owner
    assign ic_valid = (owner == own_ic) && mem_valid;
    assign ic_last  = (owner == own_ic) && mem_last;
    assign dc_valid = (owner == own_dc) && mem_valid;
    assign dc_last  = (owner == own_dc) && mem_last;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            owner <= own_none;
        end else begin
            case (owner)
                own_none: begin
                    if (dc_grant) begin
                        owner <= own_dc;
                    end else if (ic_grant) begin
                        owner <= own_ic;
                    end
                end
                own_ic, own_dc: begin
                    // held until the transaction's last beat
                    if (mem_last) begin
                        owner <= own_none;
                    end
                end
                default: owner <= own_none;
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_cache_top -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

/* sources.f */
design/cache_pkg.sv
design/icache.sv
design/dcache.sv
design/mem_arbiter.sv
design/main_memory.sv
design/cache_top.sv
testbench/tb_cache_top.sv

/* testbench/tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_FIXED   = 15;
    localparam int NUM_RANDOM  = 25;
    localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
    localparam int MAX_WAIT    = 40;

    logic             clk;
    logic             reset_n;
    logic             i_req;
    cache_pkg::addr_t i_addr;
    logic             i_done;
    cache_pkg::word_t i_data;
    logic             i_hit;
    logic             d_req;
    logic             d_we;
    cache_pkg::addr_t d_addr;
    cache_pkg::word_t d_wdata;
    logic             d_done;
    cache_pkg::word_t d_rdata;
    logic             d_hit;

    // stimulus table with port 0 for instruction and 1 for data
    logic             t_port  [NUM_ENTRIES];
    logic             t_we    [NUM_ENTRIES];
    cache_pkg::addr_t t_addr  [NUM_ENTRIES];
    cache_pkg::word_t t_wdata [NUM_ENTRIES];
    logic             t_sim   [NUM_ENTRIES];
    int               num_added;

    // reference model indexed by port first
    cache_pkg::word_t mem_model [cache_pkg::addr_t];
    logic             valid_m [2][cache_pkg::NUM_SETS];
    cache_pkg::tag_t  tag_m   [2][cache_pkg::NUM_SETS];
    cache_pkg::word_t data_m  [2][cache_pkg::NUM_SETS][cache_pkg::BLOCK_WORDS];

    logic [31:0] lcg_state;

    cache_top i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .i_req   (i_req),
        .i_addr  (i_addr),
        .i_done  (i_done),
        .i_data  (i_data),
        .i_hit   (i_hit),
        .d_req   (d_req),
        .d_we    (d_we),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_done  (d_done),
        .d_rdata (d_rdata),
        .d_hit   (d_hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_word(input string what, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t: %s data %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_hit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t: %s hit %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic cache_pkg::word_t model_read_word(input cache_pkg::addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ cache_pkg::MEM_PATTERN;
    endfunction

    task automatic add_entry(input logic port, input logic we, input cache_pkg::addr_t addr,
                             input cache_pkg::word_t wdata, input logic sim);
        t_port[num_added]  = port;
        t_we[num_added]    = we;
        t_addr[num_added]  = addr;
        t_wdata[num_added] = wdata;
        t_sim[num_added]   = sim;
        num_added++;
    endtask

    task automatic build_table();
        logic [15:0] r;
        num_added = 0;
        // instruction miss then hit in the same block
        add_entry(1'b0, 1'b0, 16'h0123, 16'h0000, 1'b0);
        add_entry(1'b0, 1'b0, 16'h0121, 16'h0000, 1'b0);
        // data miss then hit
        add_entry(1'b1, 1'b0, 16'h0450, 16'h0000, 1'b0);
        add_entry(1'b1, 1'b0, 16'h0453, 16'h0000, 1'b0);
        // write hit, reread, then the instruction side sees memory
        add_entry(1'b1, 1'b1, 16'h0451, 16'h1234, 1'b0);
        add_entry(1'b1, 1'b0, 16'h0451, 16'h0000, 1'b0);
        add_entry(1'b0, 1'b0, 16'h0451, 16'h0000, 1'b0);
        // write miss without allocation
        add_entry(1'b1, 1'b1, 16'h0888, 16'hBEEF, 1'b0);
        add_entry(1'b1, 1'b0, 16'h0888, 16'h0000, 1'b0);
        // both ports at once with two misses
        add_entry(1'b0, 1'b0, 16'h0A14, 16'h0000, 1'b1);
        add_entry(1'b1, 1'b0, 16'h0B38, 16'h0000, 1'b0);
        // conflicting tags in set 0
        add_entry(1'b1, 1'b0, 16'h1450, 16'h0000, 1'b0);
        add_entry(1'b1, 1'b0, 16'h0450, 16'h0000, 1'b0);
        add_entry(1'b0, 1'b0, 16'h1120, 16'h0000, 1'b0);
        add_entry(1'b0, 1'b0, 16'h0452, 16'h0000, 1'b0);
        // random reads over two tags per set mix hits and evictions
        while (num_added < NUM_ENTRIES) begin
            r = next_random();
            add_entry(r[7], 1'b0, {7'b0, r[6], 4'b0000, r[3:0]}, 16'h0000, 1'b0);
        end
    endtask

    // expected hit, data and latency plus the model update
    task automatic predict(input logic port, input logic we, input cache_pkg::addr_t addr,
                           input cache_pkg::word_t wdata, output logic hit,
                           output cache_pkg::word_t data, output int lat);
        cache_pkg::index_t  idx;
        cache_pkg::tag_t    atag;
        cache_pkg::offset_t off;
        int                 p;
        int                 w;
        idx  = addr[3:2];
        atag = addr[15:4];
        off  = addr[1:0];
        p    = port ? 1 : 0;
        hit  = valid_m[p][idx] && (tag_m[p][idx] == atag);
        data = '0;
        if (we) begin
            mem_model[addr] = wdata;
            if (hit) begin
                data_m[p][idx][off] = wdata;
            end
            lat = 3;
        end else if (hit) begin
            data = data_m[p][idx][off];
            lat  = 1;
        end else begin
            for (w = 0; w < cache_pkg::BLOCK_WORDS; w++) begin
                data_m[p][idx][w] = model_read_word({addr[15:2], cache_pkg::offset_t'(w)});
            end
            tag_m[p][idx]   = atag;
            valid_m[p][idx] = 1'b1;
            data            = data_m[p][idx][off];
            lat             = 6;
        end
    endtask

    task automatic drive_request(input int n);
        if (t_port[n]) begin
            d_req   = 1'b1;
            d_we    = t_we[n];
            d_addr  = t_addr[n];
            d_wdata = t_wdata[n];
        end else begin
            i_req  = 1'b1;
            i_addr = t_addr[n];
        end
    endtask

    function automatic logic port_done(input logic port);
        return port ? d_done : i_done;
    endfunction

    task automatic check_result(input int n, input logic exp_hit,
                                input cache_pkg::word_t exp_data);
        string what;
        what = $sformatf("entry %0d %s %h", n, t_port[n] ? "data" : "instr", t_addr[n]);
        check_hit(what, t_port[n] ? d_hit : i_hit, exp_hit);
        if (!t_we[n]) begin
            check_word(what, t_port[n] ? d_rdata : i_data, exp_data);
        end
    endtask

    task automatic run_single(input int n);
        logic             exp_hit;
        cache_pkg::word_t exp_data;
        int               exp_lat;
        int               cycles;
        predict(t_port[n], t_we[n], t_addr[n], t_wdata[n], exp_hit, exp_data, exp_lat);
        @(negedge clk);
        drive_request(n);
        cycles = 0;
        do begin
            @(negedge clk);
            i_req = 1'b0;
            d_req = 1'b0;
            cycles++;
            if (cycles > MAX_WAIT) begin
                stop_with_error($sformatf("entry %0d never signalled done", n));
            end
        end while (!port_done(t_port[n]));
        if (cycles != exp_lat) begin
            stop_with_error($sformatf("entry %0d finished after %0d cycles instead of %0d",
                                      n, cycles, exp_lat));
        end
        check_result(n, exp_hit, exp_data);
    endtask

    // entries n and n+1 start together and may finish in either order
    task automatic run_pair(input int n);
        logic             hit_a;
        logic             hit_b;
        cache_pkg::word_t data_a;
        cache_pkg::word_t data_b;
        int               lat_a;
        int               lat_b;
        logic             seen_a;
        logic             seen_b;
        int               cycles;
        predict(t_port[n], t_we[n], t_addr[n], t_wdata[n], hit_a, data_a, lat_a);
        predict(t_port[n+1], t_we[n+1], t_addr[n+1], t_wdata[n+1], hit_b, data_b, lat_b);
        @(negedge clk);
        drive_request(n);
        drive_request(n + 1);
        seen_a = 1'b0;
        seen_b = 1'b0;
        cycles = 0;
        while (!(seen_a && seen_b)) begin
            @(negedge clk);
            i_req = 1'b0;
            d_req = 1'b0;
            cycles++;
            if (!seen_a && port_done(t_port[n])) begin
                seen_a = 1'b1;
                check_result(n, hit_a, data_a);
            end
            if (!seen_b && port_done(t_port[n+1])) begin
                seen_b = 1'b1;
                check_result(n + 1, hit_b, data_b);
            end
            if (cycles > MAX_WAIT) begin
                stop_with_error($sformatf("entries %0d and %0d did not both complete",
                                          n, n + 1));
            end
        end
    endtask

    initial begin
        int n;
        i_req     = 1'b0;
        i_addr    = '0;
        d_req     = 1'b0;
        d_we      = 1'b0;
        d_addr    = '0;
        d_wdata   = '0;
        reset_n   = 1'b1;
        lcg_state = 32'd67303;
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                valid_m[p][s] = 1'b0;
            end
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;
        repeat (2) @(negedge clk);
        n = 0;
        while (n < NUM_ENTRIES) begin
            if (t_sim[n]) begin
                run_pair(n);
                n += 2;
            end else begin
                run_single(n);
                n++;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (NUM_ENTRIES * 20 + 100) @(posedge clk);
        stop_with_error("watchdog expired before all table entries completed");
    end

endmodule
